//--- design/lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// Address of the first instruction fetched after reset.
`define LC3B_RESET_PC 16'h0000

// Width of the APB address bus.
`define LC3B_ADDR_W 16

`endif

//--- design/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

	typedef logic [15:0] lc3b_word;

	typedef enum logic [3:0] {
		op_br   = 4'h0,
		op_add  = 4'h1,
		op_ldb  = 4'h2,
		op_stb  = 4'h3,
		op_jsr  = 4'h4,
		op_and  = 4'h5,
		op_ldr  = 4'h6,
		op_str  = 4'h7,
		op_rti  = 4'h8,
		op_not  = 4'h9,
		op_ldi  = 4'ha,
		op_sti  = 4'hb,
		op_jmp  = 4'hc,
		op_shf  = 4'hd,
		op_lea  = 4'he,
		op_trap = 4'hf
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	// Next PC select.
	localparam logic [1:0] pcmux_next   = 2'b00;
	localparam logic [1:0] pcmux_target = 2'b01;
	localparam logic [1:0] pcmux_reg    = 2'b10;

	// Operate format: ADD, AND, NOT, SHF.
	typedef struct packed {
		lc3b_opcode opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic       imm;
		logic [4:0] field;
	} lc3b_op_view;

	// Base plus offset format: LDR, STR.
	typedef struct packed {
		lc3b_opcode opcode;
		logic [2:0] dr;
		logic [2:0] base;
		logic [5:0] offset;
	} lc3b_mem_view;

	typedef union packed {
		lc3b_op_view  op;
		lc3b_mem_view mem;
	} lc3b_inst;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_word   pc;
		lc3b_word   inst;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic [2:0] sr2;
		logic [2:0] nzp;
		lc3b_aluop  aluop;
		logic       alumux_sel;
		logic       load_regfile;
		logic       load_cc;
		logic       mem_read;
		logic       mem_write;
		logic [1:0] pcmux_sel;
		logic       wdatamux_sel;
	} lc3b_ipacket;

endpackage

`default_nettype wire

//--- design/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
	import lc3b_pkg::*;

	logic     req;
	logic     we;
	lc3b_word addr;
	lc3b_word wdata;
	logic     instr;
	lc3b_word rdata;
	logic     done;

	modport requester (
		output req, we, addr, wdata, instr,
		input  rdata, done
	);

	modport arbiter (
		input  req, we, addr, wdata, instr,
		output rdata, done
	);

endinterface

`default_nettype wire

//--- design/ipacket_creator.sv
`timescale 1ns/1ps
`default_nettype none

module ipacket_creator (
	input  lc3b_pkg::lc3b_word    inst,
	input  lc3b_pkg::lc3b_word    pc,
	output lc3b_pkg::lc3b_ipacket ipacket
);
	import lc3b_pkg::*;

	lc3b_inst view;

	assign view = inst;

	always_comb begin
		// Defaults describe a no-op.
		ipacket.opcode = lc3b_opcode'(inst[15:12]);
		ipacket.pc = pc + 16'h2;
		ipacket.inst = inst;
		ipacket.dr = inst[11:9];
		ipacket.sr1 = inst[8:6];
		ipacket.sr2 = inst[2:0];
		ipacket.nzp = 3'b000;
		ipacket.aluop = alu_pass;
		ipacket.alumux_sel = 1'b0;
		ipacket.load_regfile = 1'b0;
		ipacket.load_cc = 1'b0;
		ipacket.mem_read = 1'b0;
		ipacket.mem_write = 1'b0;
		ipacket.pcmux_sel = pcmux_next;
		ipacket.wdatamux_sel = 1'b0;

		case (view.op.opcode)
			op_add, op_and: begin
				ipacket.aluop = (view.op.opcode == op_add) ? alu_add : alu_and;
				ipacket.dr = view.op.dr;
				ipacket.sr1 = view.op.sr1;
				ipacket.sr2 = view.op.field[2:0];
				ipacket.alumux_sel = view.op.imm;
				ipacket.load_regfile = 1'b1;
				ipacket.load_cc = 1'b1;
			end

			op_not: begin
				ipacket.aluop = alu_not;
				ipacket.load_regfile = 1'b1;
				ipacket.load_cc = 1'b1;
			end

			op_shf: begin
				ipacket.dr = view.op.dr;
				ipacket.sr1 = view.op.sr1;
				ipacket.alumux_sel = 1'b1;
				ipacket.load_regfile = 1'b1;
				ipacket.load_cc = 1'b1;
				// Arithmetic flag and direction pick the shift.
				case ({view.op.imm, view.op.field[4]})
					2'b01:   ipacket.aluop = alu_srl;
					2'b11:   ipacket.aluop = alu_sra;
					default: ipacket.aluop = alu_sll;
				endcase
			end

			op_br: begin
				ipacket.nzp = inst[11:9];
				ipacket.pcmux_sel = pcmux_target;
			end

			op_jmp: begin
				ipacket.pcmux_sel = pcmux_reg;
			end

			op_lea: begin
				ipacket.wdatamux_sel = 1'b1;
				ipacket.load_regfile = 1'b1;
				ipacket.load_cc = 1'b1;
			end

			op_ldr: begin
				ipacket.dr = view.mem.dr;
				ipacket.sr1 = view.mem.base;
				ipacket.aluop = alu_add;
				ipacket.alumux_sel = 1'b1;
				ipacket.mem_read = 1'b1;
				ipacket.load_regfile = 1'b1;
				ipacket.load_cc = 1'b1;
			end

			op_str: begin
				ipacket.sr1 = view.mem.base;
				ipacket.sr2 = view.mem.dr;
				ipacket.aluop = alu_add;
				ipacket.alumux_sel = 1'b1;
				ipacket.mem_write = 1'b1;
			end

			// LDB, STB, LDI, STI, JSR, RTI and TRAP retire as no-ops.
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module fetch_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	mem_port_if.requester        fetch_port,
	input  logic                 retire,
	input  logic                 redirect,
	input  lc3b_pkg::lc3b_word   next_pc,
	output logic                 inst_valid,
	output lc3b_pkg::lc3b_word   inst_word,
	output lc3b_pkg::lc3b_word   inst_pc
);
	import lc3b_pkg::*;

	lc3b_word pc;
	lc3b_word fetch_addr;
	logic     busy;
	logic     stale;
	logic     cur_valid;
	lc3b_word cur_word;
	lc3b_word cur_pc;
	logic     pf_valid;
	lc3b_word pf_word;
	lc3b_word pf_pc;
	logic     flush;
	logic     got;
	logic     issue;
	logic     cur_valid_n;
	logic     pf_valid_n;
	lc3b_word base_pc;

	// Only the fall-through is ever prefetched.
	assign flush = retire && redirect && (next_pc != cur_pc + 16'h2);
	assign got = busy && fetch_port.done && !stale && !flush;
	assign base_pc = flush ? next_pc : pc;

	always_comb begin
		cur_valid_n = cur_valid;
		pf_valid_n = pf_valid;
		if (flush) begin
			cur_valid_n = 1'b0;
			pf_valid_n = 1'b0;
		end else if (retire) begin
			cur_valid_n = pf_valid || got;
			pf_valid_n = 1'b0;
		end else if (got) begin
			if (cur_valid)
				pf_valid_n = 1'b1;
			else
				cur_valid_n = 1'b1;
		end
	end

	// At most two words are held or in flight.
	assign issue = !(busy && !fetch_port.done) && !(cur_valid_n && pf_valid_n);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `LC3B_RESET_PC;
			busy <= 1'b0;
			stale <= 1'b0;
			cur_valid <= 1'b0;
			pf_valid <= 1'b0;
		end else begin
			cur_valid <= cur_valid_n;
			pf_valid <= pf_valid_n;
			busy <= issue || (busy && !fetch_port.done);
			stale <= (flush || stale) && busy && !fetch_port.done;
			pc <= issue ? base_pc + 16'h2 : base_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			fetch_addr <= base_pc;
		if (got) begin
			if (retire || !cur_valid) begin
				cur_word <= fetch_port.rdata;
				cur_pc <= fetch_addr;
			end else begin
				pf_word <= fetch_port.rdata;
				pf_pc <= fetch_addr;
			end
		end else if (retire && pf_valid) begin
			cur_word <= pf_word;
			cur_pc <= pf_pc;
		end
	end

	assign fetch_port.req = busy;
	assign fetch_port.we = 1'b0;
	assign fetch_port.addr = fetch_addr;
	assign fetch_port.wdata = '0;
	assign fetch_port.instr = 1'b1;

	assign inst_valid = cur_valid;
	assign inst_word = cur_word;
	assign inst_pc = cur_pc;

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  inst_valid,
	input  lc3b_pkg::lc3b_ipacket ipacket,
	mem_port_if.requester         data_port,
	output logic                  retire,
	output logic                  redirect,
	output lc3b_pkg::lc3b_word    next_pc
);
	import lc3b_pkg::*;

	lc3b_word   regs [8];
	logic [2:0] cc;
	logic       retire_q;
	logic       redirect_q;
	lc3b_word   next_pc_q;
	lc3b_inst   view;
	lc3b_word   imm;
	lc3b_word   src_a;
	lc3b_word   src_b;
	lc3b_word   alu_res;
	lc3b_word   addr_res;
	lc3b_word   wb_data;
	lc3b_word   target;
	logic       is_mem;
	logic       exec_fire;
	logic       ld_done;
	logic       taken;

	assign view = ipacket.inst;
	assign is_mem = ipacket.mem_read || ipacket.mem_write;

	// The retire cycle is skipped so an instruction runs once.
	assign exec_fire = inst_valid && !retire_q && !is_mem;
	assign ld_done = inst_valid && ipacket.mem_read && data_port.done;

	always_comb begin
		case (ipacket.opcode)
			op_ldr, op_str: imm = {{9{view.mem.offset[5]}}, view.mem.offset, 1'b0};
			op_shf:         imm = {12'h000, view.op.field[3:0]};
			default:        imm = {{11{view.op.field[4]}}, view.op.field};
		endcase
	end

	assign src_a = regs[ipacket.sr1];
	assign src_b = ipacket.alumux_sel ? imm : regs[ipacket.sr2];

	always_comb begin
		case (ipacket.aluop)
			alu_add: alu_res = src_a + src_b;
			alu_and: alu_res = src_a & src_b;
			alu_not: alu_res = ~src_a;
			alu_sll: alu_res = src_a << src_b[3:0];
			alu_srl: alu_res = src_a >> src_b[3:0];
			alu_sra: alu_res = lc3b_word'($signed(src_a) >>> src_b[3:0]);
			default: alu_res = src_a;
		endcase
	end

	// PC-relative target for BR and LEA.
	assign addr_res = ipacket.pc + {{6{view.op.sr1[2]}}, ipacket.inst[8:0], 1'b0};

	assign wb_data = ipacket.mem_read ? data_port.rdata :
		(ipacket.wdatamux_sel ? addr_res : alu_res);

	assign taken = (ipacket.pcmux_sel == pcmux_reg) ||
		((ipacket.pcmux_sel == pcmux_target) && |(ipacket.nzp & cc));
	assign target = (ipacket.pcmux_sel == pcmux_reg) ? src_a : addr_res;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
			cc <= 3'b010;
			retire_q <= 1'b0;
			redirect_q <= 1'b0;
		end else begin
			retire_q <= exec_fire;
			redirect_q <= exec_fire && taken;
			if (ipacket.load_regfile && (exec_fire || ld_done))
				regs[ipacket.dr] <= wb_data;
			if (ipacket.load_cc && (exec_fire || ld_done))
				cc <= {wb_data[15], wb_data == 16'h0, !wb_data[15] && wb_data != 16'h0};
		end
	end

	always_ff @(posedge clk) begin
		if (exec_fire)
			next_pc_q <= target;
	end

	assign data_port.req = inst_valid && is_mem;
	assign data_port.we = ipacket.mem_write;
	assign data_port.addr = alu_res;
	assign data_port.wdata = regs[ipacket.sr2];
	assign data_port.instr = 1'b0;

	// Loads and stores end in the cycle their data port completes.
	assign retire = retire_q || (inst_valid && is_mem && data_port.done);
	assign redirect = redirect_q;
	assign next_pc = next_pc_q;

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module mem_arbiter (
	input  logic                     clk,
	input  logic                     rst_n,
	mem_port_if.arbiter              data_port,
	mem_port_if.arbiter              fetch_port,
	output logic                     psel,
	output logic                     penable,
	output logic                     pwrite,
	output logic [`LC3B_ADDR_W-1:0]  paddr,
	output lc3b_pkg::lc3b_word       pwdata,
	output logic [2:0]               pprot,
	input  lc3b_pkg::lc3b_word       prdata,
	input  logic                     pready
);

	typedef enum logic [1:0] {
		arb_idle,
		arb_setup,
		arb_access
	} arb_state_t;

	arb_state_t state;
	logic       grant_data;
	logic       data_ok;
	logic       fetch_ok;
	logic       data_done;
	logic       fetch_done;
	logic [15:0] rdata_q;

	// A port in its done cycle still holds req for the finished transfer.
	assign data_ok = data_port.req && !data_port.done;
	assign fetch_ok = fetch_port.req && !fetch_port.done;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= arb_idle;
			grant_data <= 1'b0;
			data_done <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			data_done <= (state == arb_access) && pready && grant_data;
			fetch_done <= (state == arb_access) && pready && !grant_data;
			case (state)
				arb_idle: begin
					if (data_ok || fetch_ok) begin
						state <= arb_setup;
						grant_data <= data_ok;
					end
				end
				arb_setup: state <= arb_access;
				arb_access: begin
					if (pready)
						state <= arb_idle;
				end
				default: state <= arb_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == arb_access && pready)
			rdata_q <= prdata;
	end

	assign psel = (state != arb_idle);
	assign penable = (state == arb_access);
	assign pwrite = grant_data ? data_port.we : fetch_port.we;
	assign paddr = grant_data ? data_port.addr : fetch_port.addr;
	assign pwdata = grant_data ? data_port.wdata : fetch_port.wdata;
	// Bit 2 marks an instruction access.
	assign pprot = {grant_data ? data_port.instr : fetch_port.instr, 2'b00};

	assign data_port.rdata = rdata_q;
	assign data_port.done = data_done;
	assign fetch_port.rdata = rdata_q;
	assign fetch_port.done = fetch_done;

endmodule

`default_nettype wire

//--- design/lc3b_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module lc3b_core (
	input  logic                     clk,
	input  logic                     rst_n,
	output logic                     psel,
	output logic                     penable,
	output logic                     pwrite,
	output logic [`LC3B_ADDR_W-1:0]  paddr,
	output lc3b_pkg::lc3b_word       pwdata,
	output logic [2:0]               pprot,
	input  lc3b_pkg::lc3b_word       prdata,
	input  logic                     pready
);
	import lc3b_pkg::*;

	mem_port_if fetch_port ();
	mem_port_if data_port ();

	logic        inst_valid;
	lc3b_word    inst_word;
	lc3b_word    inst_pc;
	lc3b_ipacket ipacket;
	logic        retire;
	logic        redirect;
	lc3b_word    next_pc;

	fetch_unit u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_port (fetch_port.requester),
		.retire     (retire),
		.redirect   (redirect),
		.next_pc    (next_pc),
		.inst_valid (inst_valid),
		.inst_word  (inst_word),
		.inst_pc    (inst_pc)
	);

	ipacket_creator u_decode (
		.inst    (inst_word),
		.pc      (inst_pc),
		.ipacket (ipacket)
	);

	exec_unit u_exec (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.ipacket    (ipacket),
		.data_port  (data_port.requester),
		.retire     (retire),
		.redirect   (redirect),
		.next_pc    (next_pc)
	);

	mem_arbiter u_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.data_port  (data_port.arbiter),
		.fetch_port (fetch_port.arbiter),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pprot      (pprot),
		.prdata     (prdata),
		.pready     (pready)
	);

endmodule

`default_nettype wire

//--- dv/lc3b_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module lc3b_checker (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    psel,
	input logic                    penable,
	input logic                    pwrite,
	input logic [`LC3B_ADDR_W-1:0] paddr,
	input logic [2:0]              pprot,
	input logic                    pready
);

	// An access phase starts only after a setup cycle.
	penable_after_setup: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(penable) |-> $past(psel) && !$past(penable)
	) else $error("penable rose without a preceding setup cycle");

	penable_with_psel: assert property (
		@(posedge clk) disable iff (!rst_n)
		penable |-> psel
	) else $error("penable high while psel is low");

	access_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		penable |-> $stable(paddr) && $stable(pwrite) && $stable(pprot)
	) else $error("address, direction or protection changed during an access");

	// The transfer stays selected until the completer is ready.
	psel_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		(psel && !pready) |=> psel
	) else $error("psel dropped before pready");

endmodule

`default_nettype wire

//--- dv/lc3b_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module lc3b_tb;
	import lc3b_pkg::*;

	// Budget of 8 instructions per store at 12 cycles each.
	localparam int store_limit = 300;
	localparam int max_cycles = store_limit * 8 * 12;
	localparam logic [3:0] unsupported_ops [7] = '{4'h2, 4'h3, 4'h4, 4'h8, 4'ha, 4'hb, 4'hf};

	typedef struct packed {
		logic     we;
		lc3b_word addr;
		lc3b_word wdata;
	} access_t;

	logic                    clk;
	logic                    rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic [`LC3B_ADDR_W-1:0] paddr;
	lc3b_word                pwdata;
	logic [2:0]              pprot;
	lc3b_word                prdata;
	logic                    pready;

	lc3b_word   prog [256];
	lc3b_word   data_mem [256];
	lc3b_word   model_data [256];
	lc3b_word   model_regs [8];
	logic [2:0] model_cc;
	lc3b_word   model_pc;
	lc3b_word   fall_pc;
	logic       discard_ok;
	access_t    exp_q [$];
	int         cycles;
	int         stores;
	int         wait_cnt;
	logic       first_seen;

	lc3b_core u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pprot   (pprot),
		.prdata  (prdata),
		.pready  (pready)
	);

	bind lc3b_core lc3b_checker u_checker (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pprot   (pprot),
		.pready  (pready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "run stopped at cycle %0d", cycles);
	endtask

	task automatic check_value(input string name, input lc3b_word expected,
		input lc3b_word actual);
		if (actual !== expected)
			stop_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	// Stores at slots 6 and 7 of every eight words and short forward branches
	// keep every loop passing a store. JMP always uses R7, which stays zero.
	task automatic gen_program();
		int         k;
		logic [2:0] dr;
		logic [2:0] sr;
		for (int i = 0; i < 256; i++) begin
			dr = 3'($urandom_range(0, 6));
			sr = 3'($urandom_range(0, 7));
			k = (i % 8 >= 6) ? 100 : $urandom_range(0, 11);
			case (k)
				0, 1: prog[i] = {4'h1, dr, sr, 6'($urandom)};
				2: prog[i] = {4'h5, dr, sr, 6'($urandom)};
				3: prog[i] = {4'h9, dr, sr, 6'h3f};
				4: prog[i] = {4'hd, dr, sr, 6'($urandom)};
				5: prog[i] = {4'he, dr, 9'($urandom)};
				6: prog[i] = {4'h6, dr, sr, 6'($urandom)};
				7, 8: prog[i] = {4'h0, 3'($urandom), 8'h00, 1'($urandom)};
				9: prog[i] = (i >= 64) ? {4'hc, 3'b000, 3'd7, 6'h00} : {4'h1, dr, sr, 6'h21};
				10, 11: prog[i] = {unsupported_ops[$urandom_range(0, 6)], 12'($urandom)};
				default: prog[i] = {4'h7, sr, 3'($urandom), 6'($urandom)};
			endcase
			data_mem[i] = 16'($urandom);
			model_data[i] = data_mem[i];
		end
	endtask

	task automatic write_reg(input logic [2:0] dr, input lc3b_word v);
		model_regs[dr] = v;
		model_cc = {v[15], v == 16'h0, !v[15] && v != 16'h0};
	endtask

	// Executes the instruction at the model PC and queues its data access.
	task automatic step_model();
		lc3b_word inst;
		lc3b_word a;
		lc3b_word b;
		lc3b_word r;
		lc3b_word addr;
		lc3b_word npc;
		lc3b_word pcoff;
		access_t  e;
		inst = prog[model_pc[8:1]];
		a = model_regs[inst[8:6]];
		b = inst[5] ? {{11{inst[4]}}, inst[4:0]} : model_regs[inst[2:0]];
		addr = a + {{9{inst[5]}}, inst[5:0], 1'b0};
		npc = model_pc + 16'h2;
		pcoff = {{6{inst[8]}}, inst[8:0], 1'b0};
		fall_pc = npc;
		case (inst[15:12])
			4'h1: write_reg(inst[11:9], a + b);
			4'h5: write_reg(inst[11:9], a & b);
			4'h9: write_reg(inst[11:9], ~a);
			4'hd: begin
				if (!inst[4])
					r = a << inst[3:0];
				else if (inst[5])
					r = $signed(a) >>> inst[3:0];
				else
					r = a >> inst[3:0];
				write_reg(inst[11:9], r);
			end
			4'he: write_reg(inst[11:9], npc + pcoff);
			4'h6: begin
				e.we = 1'b0;
				e.addr = addr;
				e.wdata = 16'h0;
				exp_q.push_back(e);
				write_reg(inst[11:9], model_data[addr[8:1]]);
			end
			4'h7: begin
				e.we = 1'b1;
				e.addr = addr;
				e.wdata = model_regs[inst[11:9]];
				exp_q.push_back(e);
				model_data[addr[8:1]] = e.wdata;
			end
			4'h0: begin
				if (|(inst[11:9] & model_cc))
					npc = npc + pcoff;
			end
			4'hc: npc = a;
			default: begin
			end
		endcase
		discard_ok = (npc != fall_pc);
		model_pc = npc;
	endtask

	task automatic check_fetch(input lc3b_word addr);
		if (addr == model_pc)
			step_model();
		else if (discard_ok && addr == fall_pc)
			discard_ok = 1'b0;
		else
			check_value("paddr", model_pc, addr);
	endtask

	task automatic finish_transfer();
		access_t e;
		check_value("pprot[1:0]", 16'h0, 16'(pprot[1:0]));
		if (pprot[2]) begin
			check_value("pwrite", 16'h0, 16'(pwrite));
			check_fetch(paddr);
		end else if (exp_q.size() == 0) begin
			stop_run("Data access arrived while the model had no load or store pending.");
		end else begin
			e = exp_q.pop_front();
			check_value("pwrite", 16'(e.we), 16'(pwrite));
			check_value("paddr", e.addr, paddr);
			if (pwrite) begin
				check_value("pwdata", e.wdata, pwdata);
				data_mem[paddr[8:1]] = pwdata;
				stores++;
			end
		end
	endtask

	initial begin
		logic     setup_s;
		logic     wait_s;
		lc3b_word rd_s;
		void'($urandom(32'h49223507));
		rst_n = 1'b0;
		pready = 1'b0;
		prdata = 16'h0;
		cycles = 0;
		stores = 0;
		wait_cnt = 0;
		first_seen = 1'b0;
		for (int i = 0; i < 8; i++)
			model_regs[i] = 16'h0;
		model_cc = 3'b010;
		model_pc = `LC3B_RESET_PC;
		fall_pc = `LC3B_RESET_PC;
		discard_ok = 1'b0;
		gen_program();

		repeat (2) begin
			@(posedge clk);
			#1;
			check_value("psel", 16'h0, 16'(psel));
		end
		rst_n = 1'b1;

		while (stores < store_limit) begin
			@(negedge clk);
			cycles++;
			if (cycles > max_cycles)
				stop_run("Timeout: the store count was not reached in time.");
			if (psel && !penable && !first_seen) begin
				first_seen = 1'b1;
				check_value("paddr", `LC3B_RESET_PC, paddr);
				check_value("pprot[2]", 16'h1, 16'(pprot[2]));
			end
			setup_s = psel && !penable;
			wait_s = psel && penable && !pready;
			rd_s = pprot[2] ? prog[paddr[8:1]] : data_mem[paddr[8:1]];
			if (psel && penable && pready)
				finish_transfer();

			@(posedge clk);
			#1;
			if (setup_s) begin
				wait_cnt = $urandom_range(0, 3);
				prdata = rd_s;
				pready = (wait_cnt == 0);
			end else if (wait_s) begin
				wait_cnt--;
				pready = (wait_cnt == 0);
			end else begin
				pready = 1'b0;
			end
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/lc3b_pkg.sv
design/mem_port_if.sv
design/ipacket_creator.sv
design/fetch_unit.sv
design/exec_unit.sv
design/mem_arbiter.sv
design/lc3b_core.sv
dv/lc3b_checker.sv
dv/lc3b_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the LC-3b core testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module lc3b_tb \
	-Mdir obj_dir -o lc3b_sim
if [ $? -ne 0 ]; then
	echo "Verilator build step returned an error"
	exit 1
fi

./obj_dir/lc3b_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi
exit 0
